/* src/minerPkg.sv */
package minerPkg;

	localparam int LaneCount = 4;
	localparam int HashWidth = 256;
	localparam int NonceWidth = 32;

	// fixed block header fields
	localparam logic [31:0] Version = 32'h02000000;
	localparam logic [255:0] PrevBlock =
		256'h000000000000000000fc6ee494a6cc0b9c6a72ad53ad1ffccbd352536efd00af;
	localparam logic [255:0] MerkleRoot =
		256'h5b3c9d0e71a2f4486e0b1d93c7a85f2e4d16b03a9c2e7f5180d4a6b3e9f1c027;
	localparam logic [31:0] Timestamp = 32'h5840905C;
	localparam logic [31:0] Bits = 32'h1b0404cb;

	// difficulty 7 target
	localparam logic [255:0] EasiestTarget = {24'h0404CB, 232'd0};

	localparam logic [0:63][31:0] RoundK = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
		32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
		32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
		32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
		32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
		32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	localparam logic [255:0] InitHash = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	typedef struct packed {
		logic valid;
		logic [NonceWidth-1:0] nonce;
	} laneJob;

	// hash is already byte reversed, compare as a plain number
	typedef struct packed {
		logic valid;
		logic [NonceWidth-1:0] nonce;
		logic [HashWidth-1:0] hash;
	} laneResult;

	typedef struct packed {
		logic done;
		logic hit;
	} batchStatus;

endpackage

/* src/sha256Rounds.sv */
`timescale 1ns/10ps

module sha256Rounds (
	input logic pulse,
	input logic rst,
	input logic start,
	input logic [minerPkg::HashWidth-1:0] chainIn,
	input logic [2*minerPkg::HashWidth-1:0] block,
	output logic [minerPkg::HashWidth-1:0] digest,
	output logic done
);

	logic [0:7][31:0] vars;
	logic [0:7][31:0] curVars;
	logic [0:7][31:0] nextVars;
	logic [0:7][31:0] chainWords;
	logic [0:7][31:0] digestWords;
	logic [0:15][31:0] window;
	logic [0:15][31:0] curWindow;
	logic [0:15][31:0] nextWindow;
	logic [31:0] roundK;
	logic [6:0] rnd;
	logic busy;

	function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	assign chainWords = chainIn;
	assign digest = digestWords;

	// round 0 runs straight from the inputs in the start cycle
	assign curVars = start ? chainWords : vars;
	assign curWindow = start ? block : window;
	assign roundK = minerPkg::RoundK[start ? 6'd0 : rnd[5:0]];

	always_comb
	begin
		logic [31:0] sigE;
		logic [31:0] sigA;
		logic [31:0] ch;
		logic [31:0] maj;
		logic [31:0] t1;
		logic [31:0] t2;
		logic [31:0] s0;
		logic [31:0] s1;
		sigE = rotr(curVars[4], 6) ^ rotr(curVars[4], 11) ^ rotr(curVars[4], 25);
		ch = (curVars[4] & curVars[5]) ^ (~curVars[4] & curVars[6]);
		t1 = curVars[7] + sigE + ch + roundK + curWindow[0];
		sigA = rotr(curVars[0], 2) ^ rotr(curVars[0], 13) ^ rotr(curVars[0], 22);
		maj = (curVars[0] & curVars[1]) ^ (curVars[0] & curVars[2]) ^ (curVars[1] & curVars[2]);
		t2 = sigA + maj;
		nextVars = {t1 + t2, curVars[0:2], curVars[3] + t1, curVars[4:6]};
		// schedule window slides one word per round
		s0 = rotr(curWindow[1], 7) ^ rotr(curWindow[1], 18) ^ (curWindow[1] >> 3);
		s1 = rotr(curWindow[14], 17) ^ rotr(curWindow[14], 19) ^ (curWindow[14] >> 10);
		nextWindow = {curWindow[1:15], s1 + curWindow[9] + s0 + curWindow[0]};
	end

	always_ff @(posedge pulse or negedge rst)
	begin
		if (!rst)
		begin
			busy <= 1'b0;
			rnd <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				busy <= 1'b1;
				rnd <= 7'd1;
			end
			else if (busy)
			begin
				if (rnd == 7'd64)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				rnd <= rnd + 7'd1;
			end
		end
	end

	always_ff @(posedge pulse)
	begin
		if (start || (busy && rnd != 7'd64))
		begin
			vars <= nextVars;
			window <= nextWindow;
		end
		// feed forward
		if (busy && rnd == 7'd64)
		begin
			for (int i = 0; i < 8; i++)
			begin
				digestWords[i] <= chainWords[i] + vars[i];
			end
		end
	end

	assert property (@(posedge pulse) disable iff (!rst) start |-> !busy)
		else $error("sha256Rounds got start while busy");

endmodule

/* src/minerLane.sv */
`timescale 1ns/10ps

module minerLane (
	input logic pulse,
	input logic rst,
	input minerPkg::laneJob job,
	output minerPkg::laneResult result
);

	logic [minerPkg::NonceWidth-1:0] nonce;
	logic [minerPkg::HashWidth-1:0] chain;
	logic [minerPkg::HashWidth-1:0] digest;
	logic [minerPkg::HashWidth-1:0] reversed;
	logic [minerPkg::HashWidth-1:0] resHash;
	logic [2*minerPkg::HashWidth-1:0] block;
	logic [1:0] step;
	logic [1:0] phase;
	logic busy;
	logic kick;
	logic engStart;
	logic engDone;
	logic resValid;

	// compression that owns the engine inputs in this cycle
	assign phase = kick ? 2'd0 : (engDone ? step + 2'd1 : step);
	assign engStart = kick || (engDone && step != 2'd2);

	// first digest stays on the engine output through the second feed forward
	assign chain = (phase == 2'd1) ? digest : minerPkg::InitHash;

	always_comb
	begin
		case (phase)
			2'd0: block = {minerPkg::Version, minerPkg::PrevBlock, minerPkg::MerkleRoot[255:32]};
			2'd1: block = {minerPkg::MerkleRoot[31:0], minerPkg::Timestamp, minerPkg::Bits,
				nonce, 1'b1, 319'd0, 64'd640};
			default: block = {digest, 1'b1, 191'd0, 64'd256};
		endcase
	end

	always_comb
	begin
		for (int i = 0; i < minerPkg::HashWidth / 8; i++)
		begin
			reversed[8*i +: 8] = digest[minerPkg::HashWidth - 8 - 8*i +: 8];
		end
	end

	sha256Rounds engine_i (
		.pulse,
		.rst,
		.start(engStart),
		.chainIn(chain),
		.block,
		.digest,
		.done(engDone)
	);

	always_ff @(posedge pulse or negedge rst)
	begin
		if (!rst)
		begin
			busy <= 1'b0;
			kick <= 1'b0;
			step <= 2'd0;
			resValid <= 1'b0;
		end
		else
		begin
			kick <= job.valid;
			resValid <= 1'b0;
			if (job.valid)
			begin
				busy <= 1'b1;
				step <= 2'd0;
			end
			else if (engDone)
			begin
				if (step == 2'd2)
				begin
					busy <= 1'b0;
					resValid <= 1'b1;
				end
				else
				begin
					step <= step + 2'd1;
				end
			end
		end
	end

	always_ff @(posedge pulse)
	begin
		if (job.valid)
			nonce <= job.nonce;
		if (engDone && step == 2'd2)
			resHash <= reversed;
	end

	assign result = '{valid: resValid, nonce: nonce, hash: resHash};

	assert property (@(posedge pulse) disable iff (!rst) job.valid |-> !busy)
		else $error("minerLane got a job while busy");

endmodule

/* src/nonceDispatch.sv */
`timescale 1ns/10ps

module nonceDispatch (
	input logic pulse,
	input logic rst,
	input logic start,
	input minerPkg::batchStatus status,
	output minerPkg::laneJob [minerPkg::LaneCount-1:0] jobs
);

	logic running;
	logic issue;
	logic [minerPkg::NonceWidth-1:0] base;

	always_ff @(posedge pulse or negedge rst)
	begin
		if (!rst)
		begin
			running <= 1'b0;
			issue <= 1'b0;
			base <= '0;
		end
		else
		begin
			issue <= 1'b0;
			// the search is already over in the cycle that reports the hit
			if (start && (!running || status.hit))
			begin
				running <= 1'b1;
				issue <= 1'b1;
				base <= '0;
			end
			else if (status.done)
			begin
				if (status.hit)
					running <= 1'b0;
				else
				begin
					// wraps to zero past the last batch
					base <= base + minerPkg::LaneCount;
					issue <= 1'b1;
				end
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < minerPkg::LaneCount; i++)
		begin
			jobs[i].valid = issue;
			jobs[i].nonce = base + i;
		end
	end

	assert property (@(posedge pulse) disable iff (!rst) status.done |-> running)
		else $error("batch status with no batch outstanding");

endmodule

/* src/winnerSelect.sv */
`timescale 1ns/10ps

module winnerSelect (
	input logic pulse,
	input logic rst,
	input logic start,
	input logic [2:0] difficulty,
	input minerPkg::laneResult [minerPkg::LaneCount-1:0] results,
	output minerPkg::batchStatus status,
	output logic found,
	output minerPkg::laneResult winner
);

	logic [minerPkg::HashWidth-1:0] target;
	logic [minerPkg::HashWidth-1:0] winHash;
	logic [minerPkg::NonceWidth-1:0] winNonce;
	logic [minerPkg::LaneCount-1:0] allValid;
	logic [minerPkg::LaneCount-1:0] below;
	logic [$clog2(minerPkg::LaneCount)-1:0] pick;
	logic searching;

	// lowest lane under target wins
	always_comb
	begin
		pick = '0;
		for (int i = minerPkg::LaneCount - 1; i >= 0; i--)
		begin
			allValid[i] = results[i].valid;
			below[i] = results[i].hash < target;
			if (below[i])
				pick = $bits(pick)'(i);
		end
	end

	always_ff @(posedge pulse or negedge rst)
	begin
		if (!rst)
		begin
			searching <= 1'b0;
			found <= 1'b0;
			status <= '0;
		end
		else
		begin
			status <= '0;
			if (start && !searching)
			begin
				searching <= 1'b1;
				found <= 1'b0;
			end
			else if (allValid[0])
			begin
				status <= '{done: 1'b1, hit: |below};
				if (|below)
				begin
					searching <= 1'b0;
					found <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge pulse)
	begin
		// each difficulty step is one hex digit
		if (start && !searching)
			target <= minerPkg::EasiestTarget >> {3'd7 - difficulty, 2'b00};
		if (allValid[0] && |below)
		begin
			winNonce <= results[pick].nonce;
			winHash <= results[pick].hash;
		end
	end

	assign winner = '{valid: found, nonce: winNonce, hash: winHash};

	assert property (@(posedge pulse) disable iff (!rst) (allValid == '0) || (&allValid))
		else $error("lane results out of step");

endmodule

/* src/hexDisplay.sv */
`timescale 1ns/10ps

module hexDisplay (
	input logic pulse,
	input logic rst,
	input logic found,
	input logic [minerPkg::HashWidth-1:0] hash,
	input logic [5:0] place,
	output logic [6:0] segments
);

	logic [3:0] nibble;
	logic [6:0] pattern;

	// place 0 is the top nibble
	assign nibble = hash[{~place, 2'b00} +: 4];

	always_comb
	begin
		case (nibble)
			4'h0: pattern = 7'h3F;
			4'h1: pattern = 7'h06;
			4'h2: pattern = 7'h5B;
			4'h3: pattern = 7'h4F;
			4'h4: pattern = 7'h66;
			4'h5: pattern = 7'h6D;
			4'h6: pattern = 7'h7D;
			4'h7: pattern = 7'h07;
			4'h8: pattern = 7'h7F;
			4'h9: pattern = 7'h6F;
			4'hA: pattern = 7'h77;
			4'hB: pattern = 7'h7C;
			4'hC: pattern = 7'h39;
			4'hD: pattern = 7'h5E;
			4'hE: pattern = 7'h79;
			default: pattern = 7'h71;
		endcase
	end

	always_ff @(posedge pulse or negedge rst)
	begin
		if (!rst)
			segments <= 7'h00;
		else
			segments <= found ? pattern : 7'h00;
	end

endmodule

/* src/minerTop.sv */
`timescale 1ns/10ps

module minerTop (
	input logic pulse,
	input logic rst,
	input logic start,
	input logic [2:0] difficulty,
	input logic [5:0] place,
	output logic [6:0] segments,
	output logic found,
	output logic [minerPkg::NonceWidth-1:0] foundNonce,
	output logic [minerPkg::HashWidth-1:0] foundHash
);

	minerPkg::laneJob [minerPkg::LaneCount-1:0] jobs;
	minerPkg::laneResult [minerPkg::LaneCount-1:0] results;
	minerPkg::batchStatus status;
	minerPkg::laneResult winner;

	nonceDispatch dispatch_i (
		.pulse,
		.rst,
		.start,
		.status,
		.jobs
	);

	for (genvar i = 0; i < minerPkg::LaneCount; i++)
	begin : laneGen
		minerLane lane_i (
			.pulse,
			.rst,
			.job(jobs[i]),
			.result(results[i])
		);
	end

	winnerSelect select_i (
		.pulse,
		.rst,
		.start,
		.difficulty,
		.results,
		.status,
		.found,
		.winner
	);

	hexDisplay display_i (
		.pulse,
		.rst,
		.found(winner.valid),
		.hash(winner.hash),
		.place,
		.segments
	);

	assign foundNonce = winner.nonce;
	assign foundHash = winner.hash;

endmodule

/* include/sha256Model.svh */
`ifndef SHA256_MODEL_SVH
`define SHA256_MODEL_SVH

function automatic logic [31:0] mdlRotr(input logic [31:0] x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

// one full compression, all rounds at once
function automatic logic [255:0] mdlCompress(input logic [255:0] chain,
	input logic [511:0] block);
	logic [31:0] w [64];
	logic [31:0] v [8];
	logic [31:0] t1;
	logic [31:0] t2;
	logic [255:0] outHash;
	for (int i = 0; i < 16; i++)
		w[i] = block[511 - 32*i -: 32];
	for (int i = 16; i < 64; i++)
		w[i] = (mdlRotr(w[i-2], 17) ^ mdlRotr(w[i-2], 19) ^ (w[i-2] >> 10)) + w[i-7]
			+ (mdlRotr(w[i-15], 7) ^ mdlRotr(w[i-15], 18) ^ (w[i-15] >> 3)) + w[i-16];
	for (int i = 0; i < 8; i++)
		v[i] = chain[255 - 32*i -: 32];
	for (int i = 0; i < 64; i++)
	begin
		t1 = v[7] + (mdlRotr(v[4], 6) ^ mdlRotr(v[4], 11) ^ mdlRotr(v[4], 25))
			+ ((v[4] & v[5]) ^ (~v[4] & v[6])) + minerPkg::RoundK[i] + w[i];
		t2 = (mdlRotr(v[0], 2) ^ mdlRotr(v[0], 13) ^ mdlRotr(v[0], 22))
			+ ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		for (int j = 7; j > 0; j--)
			v[j] = v[j-1];
		v[4] = v[4] + t1;
		v[0] = t1 + t2;
	end
	for (int i = 0; i < 8; i++)
		outHash[255 - 32*i -: 32] = chain[255 - 32*i -: 32] + v[i];
	return outHash;
endfunction

// byte reversed double hash of the header with this nonce
function automatic logic [255:0] mdlHash(input logic [31:0] nonce);
	logic [639:0] header;
	logic [255:0] mid;
	logic [255:0] first;
	logic [255:0] second;
	logic [255:0] reversed;
	header = {minerPkg::Version, minerPkg::PrevBlock, minerPkg::MerkleRoot,
		minerPkg::Timestamp, minerPkg::Bits, nonce};
	mid = mdlCompress(minerPkg::InitHash, header[639:128]);
	first = mdlCompress(mid, {header[127:0], 1'b1, 319'd0, 64'd640});
	second = mdlCompress(minerPkg::InitHash, {first, 1'b1, 191'd0, 64'd256});
	for (int i = 0; i < 32; i++)
		reversed[8*i +: 8] = second[255 - 8*i -: 8];
	return reversed;
endfunction

function automatic logic [255:0] mdlTarget(input logic [2:0] difficulty);
	logic [255:0] target;
	target = {24'h0404CB, 232'd0};
	for (int i = difficulty; i < 7; i++)
		target = target / 16;
	return target;
endfunction

// active high, gfedcba
function automatic logic [6:0] mdlSegments(input logic [3:0] nibble);
	logic [6:0] table16 [16];
	table16 = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
		7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
	return table16[nibble];
endfunction

`endif

/* test/minerTb.sv */
`timescale 1ns/10ps

module minerTb;

	`include "sha256Model.svh"

	localparam int Timeout = 1000000;

	logic pulse;
	logic rst;
	logic start;
	logic [2:0] difficulty;
	logic [5:0] place;
	logic [6:0] segments;
	logic found;
	logic [31:0] foundNonce;
	logic [255:0] foundHash;
	integer seed;
	int errors;

	minerTop dut_i (
		.pulse,
		.rst,
		.start,
		.difficulty,
		.place,
		.segments,
		.found,
		.foundNonce,
		.foundHash
	);

	initial
	begin
		pulse = 1'b0;
		forever #4 pulse = ~pulse;
	end

	// found may only drop right after a start
	assert property (@(posedge pulse) disable iff (!rst) $fell(found) |-> $past(start))
	else
	begin
		errors++;
		$display("found went low although no start was issued");
	end

	task automatic tick();
		@(posedge pulse);
		#1;
	endtask

	task automatic checkValue(input string name, input logic [255:0] expected,
		input logic [255:0] actual);
		assert (expected === actual)
		else
		begin
			errors++;
			$display("Fail %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic waitFound(output bit ok);
		int count;
		count = 0;
		while (!found && count < Timeout)
		begin
			tick();
			count++;
		end
		ok = found;
		if (!ok)
		begin
			errors++;
			$display("timed out waiting for found after %0d cycles", Timeout);
		end
	endtask

	task automatic runStart(input logic [2:0] level);
		difficulty = level;
		start = 1'b1;
		tick();
		start = 1'b0;
		checkValue("startClearsFound", 0, found);
	endtask

	// winner hash is right and no smaller nonce meets the target
	task automatic checkSearch(input string name, input logic [2:0] level);
		logic [255:0] target;
		logic [255:0] h;
		logic [31:0] n;
		target = mdlTarget(level);
		checkValue({name, "Hash"}, mdlHash(foundNonce), foundHash);
		assert (foundHash < target)
		else
		begin
			errors++;
			$display("Fail %sBelow expected below %0h actual %0h", name, target, foundHash);
		end
		for (n = 0; n < foundNonce; n++)
		begin
			h = mdlHash(n);
			assert (!(h < target))
			else
			begin
				errors++;
				$display("Fail %sFirst expected nonce %0d actual %0d", name, n, foundNonce);
			end
		end
	endtask

	initial
	begin
		bit ok;
		int rnd;
		logic [31:0] heldNonce;
		logic [255:0] heldHash;
		seed = 55;
		errors = 0;
		rst = 1'b0;
		start = 1'b0;
		difficulty = 3'd7;
		place = 6'd0;
		repeat (16) tick();
		rst = 1'b1;
		repeat (4) tick();
		checkValue("resetFound", 0, found);
		checkValue("resetSegments", 0, segments);

		runStart(3'd7);
		waitFound(ok);
		if (ok)
		begin
			checkSearch("diff7", 3'd7);
			heldNonce = foundNonce;
			heldHash = mdlHash(foundNonce);
			for (int i = 0; i < 8; i++)
			begin
				rnd = $random(seed);
				place = rnd[5:0];
				tick();
				checkValue("display", mdlSegments(heldHash[255 - 4*place -: 4]), segments);
			end
			// no start, so the winner must stay put
			difficulty = 3'd2;
			repeat (20) tick();
			checkValue("holdFound", 1, found);
			checkValue("holdNonce", heldNonce, foundNonce);
			checkValue("holdHash", heldHash, foundHash);

			runStart(3'd6);
			waitFound(ok);
			if (ok)
				checkSearch("diff6", 3'd6);
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* src.f */
+incdir+include
src/minerPkg.sv
src/sha256Rounds.sv
src/minerLane.sv
src/nonceDispatch.sv
src/winnerSelect.sv
src/hexDisplay.sv
src/minerTop.sv
test/minerTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module minerTb -o minerSim

out=$(./obj_dir/minerSim)
echo "$out"

echo "$out" | grep -q "SIMULATION PASSED"
